// ==== common/bch_config.svh ====
/*
  code and array sizes for the extended BCH(16,5) encoder
  BCH_GPOLY holds the 11-bit generator, x^10 term included
  BCH_LANES must be 2 or more, BCH_FIFO_DEPTH a power of two
*/

`ifndef BCH_CONFIG_SVH
`define BCH_CONFIG_SVH

//------------------------------------------------------------
// code geometry
//------------------------------------------------------------

`define BCH_N          15       // base code length
`define BCH_K          5        // message bits
`define BCH_NPAR       10       // parity bits, n - k
`define BCH_GPOLY      11'h537  // x^10+x^8+x^5+x^4+x^2+x+1

//------------------------------------------------------------
// array sizes
//------------------------------------------------------------

`define BCH_LANES      4        // serial encoder lanes
`define BCH_FIFO_DEPTH 4        // codeword fifo entries

`endif

// ==== common/bch_pkg.sv ====
/*
  shared vector types and the lane state enum
  widths follow the sizes in the config header
*/

`include "bch_config.svh"

package bch_pkg;

  typedef logic [`BCH_K-1:0]    msg_t;  // message, bit 4 goes out first
  typedef logic [`BCH_NPAR-1:0] par_t;  // lfsr state
  typedef logic [`BCH_N:0]      cw_t;   // data 15..11, parity 10..1, even bit 0

  typedef logic [$clog2(`BCH_LANES)-1:0]    lane_id_t;
  typedef logic [$clog2(`BCH_N+1)-1:0]      bit_cnt_t;  // serial step
  typedef logic [$clog2(`BCH_FIFO_DEPTH):0] fifo_cnt_t; // 0..depth

  typedef logic [1:0]  wb_adr_t;
  typedef logic [31:0] wb_dat_t;

  typedef enum logic [2:0] {
    IDLE,
    DATA,
    PARITY,
    EVEN,
    DONE
  } lane_state_e;

endpackage

// ==== common/bch_if.sv ====
/*
  lane handshake and codeword read port
  lane takes load && !busy, releases cw on done && ack
  pop only counts while rdy is high
*/

`timescale 1ns/1ps

interface bch_lane_if;

  logic            load;  // dispatcher hands over msg
  bch_pkg::msg_t   msg;
  logic            busy;  // lane occupied, done included
  logic            done;  // cw valid, held until ack
  bch_pkg::cw_t    cw;
  logic            ack;   // collector took cw

  modport dispatch (output load, output msg, input busy);
  modport lane     (input load, input msg, input ack,
                    output busy, output done, output cw);
  modport collect  (input done, input cw, output ack);

endinterface

interface bch_rd_if;

  logic                pop;   // from bus slave
  logic                rdy;   // fifo not empty
  bch_pkg::cw_t        cw;    // head entry
  bch_pkg::fifo_cnt_t  count;

  modport host (output pop, input rdy, input cw, input count);
  modport fifo (input pop, output rdy, output cw, output count);

endinterface

// ==== rtl/bch_wb_slave.sv ====
/*
  wishbone classic slave, no err/rty
  write 0 waits for a free lane, read 1 waits for a codeword
  master must drop stb after ack, no new request in the ack cycle
*/

`timescale 1ns/1ps

`include "bch_config.svh"

module bch_wb_slave (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  bch_pkg::wb_adr_t  wb_adr,
  input  bch_pkg::wb_dat_t  wb_wdat,
  output bch_pkg::wb_dat_t  wb_rdat,
  output logic              wb_ack,
  output logic              msg_valid,
  output bch_pkg::msg_t     msg,
  input  logic              msg_taken,
  input  logic              lane_free,
  bch_rd_if.host            rd
);

  localparam bch_pkg::wb_adr_t ADR_MSG  = 2'd0;
  localparam bch_pkg::wb_adr_t ADR_CW   = 2'd1;
  localparam bch_pkg::wb_adr_t ADR_STAT = 2'd2;

  logic              req;
  logic              msg_wr;
  logic              cw_rd;
  logic              ack_next;
  bch_pkg::wb_dat_t  rdat_next;

  //------------------------------------------------------------
  // decode, request is held until its condition holds
  //------------------------------------------------------------

  always_comb begin
    req    = wb_cyc && wb_stb && !wb_ack;  // ack cycle is dead time
    msg_wr = req && wb_we && (wb_adr == ADR_MSG);
    cw_rd  = req && !wb_we && (wb_adr == ADR_CW);

    msg_valid = msg_wr;
    rd.pop    = cw_rd && rd.rdy;  // fifo steps on the edge raising ack

    if (msg_wr) begin
      ack_next = msg_taken;       // wait state until a lane is free
    end else if (cw_rd) begin
      ack_next = rd.rdy;          // wait state while fifo empty
    end else begin
      ack_next = req;             // status, unmapped
    end
  end

  assign msg = wb_wdat[`BCH_K-1:0];

  // read mux
  always_comb begin
    rdat_next = '0;
    if (!wb_we && (wb_adr == ADR_CW)) begin
      rdat_next[$bits(bch_pkg::cw_t)-1:0] = rd.cw;
    end else if (!wb_we && (wb_adr == ADR_STAT)) begin
      rdat_next[0] = lane_free;
      rdat_next[1] = rd.rdy;
      rdat_next[4 +: $bits(bch_pkg::fifo_cnt_t)] = rd.count;
    end
  end

  //------------------------------------------------------------
  // registered ack and read data
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= ack_next;  // single pulse, req masks the ack cycle
    end
  end

  always_ff @(posedge iclk) begin
    if (ack_next) begin
      wb_rdat <= rdat_next;
    end
  end

endmodule

// ==== rtl/bch_dispatch.sv ====
/*
  round-robin hand-off of messages to the lanes
  no lane is skipped, so a busy lane at the pointer stalls the bus
*/

`timescale 1ns/1ps

`include "bch_config.svh"

module bch_dispatch (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           msg_valid,
  input  bch_pkg::msg_t  msg,
  output logic           msg_taken,
  output logic           lane_free,
  bch_lane_if.dispatch   lanes [`BCH_LANES]
);

  bch_pkg::lane_id_t      ptr;      // next lane in order
  logic [`BCH_LANES-1:0]  busy_vec;

  for (genvar i = 0; i < `BCH_LANES; i++) begin : g_lane
    assign busy_vec[i] = lanes[i].busy;
    // load only at the pointer, never into a busy lane
    assign lanes[i].load = msg_valid && (ptr == bch_pkg::lane_id_t'(i)) && !busy_vec[i];
    assign lanes[i].msg  = msg;
  end

  assign lane_free = !busy_vec[ptr];
  assign msg_taken = msg_valid && lane_free;  // same cycle as load

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ptr <= '0;
    end else if (msg_taken) begin
      if (ptr == bch_pkg::lane_id_t'(`BCH_LANES-1)) begin
        ptr <= '0;  // wrap, lane count need not be a power of two
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

endmodule

// ==== bch_enc/bch_enc_lane.sv ====
/*
  one bit-serial extended BCH(16,5) encoder lane
  16 steps: 5 data, 10 parity, 1 even bit, packed msb first
  fixed generator from the config header, codeword held until ack
*/

`timescale 1ns/1ps

`include "bch_config.svh"

module bch_enc_lane (
  input  logic      iclk,
  input  logic      ireset,
  bch_lane_if.lane  lane
);

  localparam logic [`BCH_NPAR:0] GPOLY = `BCH_GPOLY;

  localparam bch_pkg::bit_cnt_t LAST_DATA = bch_pkg::bit_cnt_t'(`BCH_K - 1);
  localparam bch_pkg::bit_cnt_t LAST_PAR  = bch_pkg::bit_cnt_t'(`BCH_N - 1);

  bch_pkg::lane_state_e  state;
  bch_pkg::bit_cnt_t     cnt;     // step index 0..15
  bch_pkg::msg_t         msg_sr;  // data shifter, top bit first
  bch_pkg::par_t         lfsr;
  bch_pkg::par_t         lfsr_next;
  bch_pkg::cw_t          cw_r;    // packer
  logic                  even;    // running parity of sent bits
  logic                  fb;
  logic                  out_bit;
  logic                  start;
  logic                  step;

  assign start = lane.load && !lane.busy;
  assign step  = (state == bch_pkg::DATA) || (state == bch_pkg::PARITY) ||
                 (state == bch_pkg::EVEN);

  //------------------------------------------------------------
  // sequencer
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= bch_pkg::IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        bch_pkg::IDLE: begin
          if (start) begin
            state <= bch_pkg::DATA;
            cnt   <= '0;
          end
        end
        bch_pkg::DATA: begin
          cnt <= cnt + 1'b1;
          if (cnt == LAST_DATA) state <= bch_pkg::PARITY;
        end
        bch_pkg::PARITY: begin
          cnt <= cnt + 1'b1;
          if (cnt == LAST_PAR) state <= bch_pkg::EVEN;
        end
        bch_pkg::EVEN: state <= bch_pkg::DONE;            // step 16
        bch_pkg::DONE: if (lane.ack) state <= bch_pkg::IDLE;
        default: state <= bch_pkg::IDLE;
      endcase
    end
  end

  //------------------------------------------------------------
  // lfsr and output bit
  //------------------------------------------------------------

  always_comb begin
    // feedback only while data streams, zero shifts parity out
    fb = (state == bch_pkg::DATA) ? (msg_sr[`BCH_K-1] ^ lfsr[`BCH_NPAR-1]) : 1'b0;
    lfsr_next[0] = GPOLY[0] & fb;
    for (int i = 1; i < `BCH_NPAR; i++) begin
      lfsr_next[i] = lfsr[i-1] ^ (GPOLY[i] & fb);
    end
  end

  always_comb begin
    case (state)
      bch_pkg::DATA:   out_bit = msg_sr[`BCH_K-1];
      bch_pkg::PARITY: out_bit = lfsr[`BCH_NPAR-1];
      bch_pkg::EVEN:   out_bit = even;
      default:         out_bit = 1'b0;
    endcase
  end

  // datapath, loaded on start
  always_ff @(posedge iclk) begin
    if (start) begin
      msg_sr <= lane.msg;
      lfsr   <= '0;
      even   <= 1'b0;
    end else if (step) begin
      msg_sr <= msg_sr << 1;
      lfsr   <= lfsr_next;
      even   <= even ^ out_bit;  // last update in EVEN is don't care
      cw_r   <= {cw_r[$bits(bch_pkg::cw_t)-2:0], out_bit};
    end
  end

  assign lane.busy = (state != bch_pkg::IDLE);
  assign lane.done = (state == bch_pkg::DONE);
  assign lane.cw   = cw_r;

endmodule

// ==== rtl/bch_collect.sv ====
/*
  drains done lanes in round-robin order into the codeword fifo
  a full fifo leaves the lane at the pointer holding done
  codeword visible one cycle after done && ack
*/

`timescale 1ns/1ps

`include "bch_config.svh"

module bch_collect (
  input  logic         iclk,
  input  logic         ireset,
  bch_lane_if.collect  lanes [`BCH_LANES],
  bch_rd_if.fifo       rd
);

  localparam int AW = $clog2(`BCH_FIFO_DEPTH);

  bch_pkg::lane_id_t      ptr;  // drain pointer
  logic [`BCH_LANES-1:0]  done_vec;
  bch_pkg::cw_t           cw_vec [`BCH_LANES];
  bch_pkg::cw_t           mem [`BCH_FIFO_DEPTH];
  logic [AW-1:0]          wr_ptr;
  logic [AW-1:0]          rd_ptr;
  bch_pkg::fifo_cnt_t     count;
  logic                   full;
  logic                   push;
  logic                   pop;

  assign full = (count == bch_pkg::fifo_cnt_t'(`BCH_FIFO_DEPTH));
  assign push = done_vec[ptr] && !full;
  assign pop  = rd.pop && rd.rdy;

  for (genvar i = 0; i < `BCH_LANES; i++) begin : g_lane
    assign done_vec[i]  = lanes[i].done;
    assign cw_vec[i]    = lanes[i].cw;
    assign lanes[i].ack = done_vec[i] && !full && (ptr == bch_pkg::lane_id_t'(i));
  end

  //------------------------------------------------------------
  // pointers and occupancy
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ptr    <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        ptr    <= (ptr == bch_pkg::lane_id_t'(`BCH_LANES-1)) ? '0 : ptr + 1'b1;
        wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
      end
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
    end
  end

  always_ff @(posedge iclk) begin
    if (push) mem[wr_ptr] <= cw_vec[ptr];
  end

  assign rd.rdy   = (count != '0);
  assign rd.cw    = mem[rd_ptr];  // head, valid while rdy
  assign rd.count = count;

endmodule

// ==== rtl/bch_enc_top.sv ====
/*
  multi-lane extended BCH(16,5) encoder behind a wishbone classic slave
  codewords come back in write order, latency varies
  poll status bit 1 or let the address 1 read wait
*/

`timescale 1ns/1ps

`include "bch_config.svh"

module bch_enc_top (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  bch_pkg::wb_adr_t  wb_adr,
  input  bch_pkg::wb_dat_t  wb_wdat,
  output bch_pkg::wb_dat_t  wb_rdat,
  output logic              wb_ack
);

  logic           msg_valid;
  bch_pkg::msg_t  msg;
  logic           msg_taken;
  logic           lane_free;

  bch_lane_if lane_if [`BCH_LANES] ();
  bch_rd_if   rd_if ();

  //------------------------------------------------------------
  // bus side
  //------------------------------------------------------------

  bch_wb_slave i_bch_wb_slave (
    .iclk      (iclk),
    .ireset    (ireset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_wdat   (wb_wdat),
    .wb_rdat   (wb_rdat),
    .wb_ack    (wb_ack),
    .msg_valid (msg_valid),
    .msg       (msg),
    .msg_taken (msg_taken),
    .lane_free (lane_free),
    .rd        (rd_if.host)
  );

  bch_dispatch i_bch_dispatch (
    .iclk      (iclk),
    .ireset    (ireset),
    .msg_valid (msg_valid),
    .msg       (msg),
    .msg_taken (msg_taken),
    .lane_free (lane_free),
    .lanes     (lane_if)
  );

  //------------------------------------------------------------
  // encoder lanes and collector
  //------------------------------------------------------------

  for (genvar i = 0; i < `BCH_LANES; i++) begin : g_lane
    bch_enc_lane i_bch_enc_lane (
      .iclk   (iclk),
      .ireset (ireset),
      .lane   (lane_if[i])
    );
  end

  bch_collect i_bch_collect (
    .iclk   (iclk),
    .ireset (ireset),
    .lanes  (lane_if),
    .rd     (rd_if.fifo)
  );

endmodule

// ==== dv/bch_enc_properties.sv ====
/*
  bus, lane and fifo invariants, bound into bch_enc_top
  fail_cnt mirrors the assertion failures for the final verdict
*/

`timescale 1ns/1ps

`include "bch_config.svh"

module bch_enc_properties (
  input  logic  iclk,
  input  logic  ireset,
  input  logic  wb_ack,
  bch_lane_if   lanes [`BCH_LANES],
  bch_rd_if     rd
);

  int fail_cnt = 0;  // read by the testbench at the end

  //------------------------------------------------------------
  // bus and fifo
  //------------------------------------------------------------

  a_ack_pulse: assert property (@(posedge iclk) disable iff (ireset)
    wb_ack |=> !wb_ack)
    else begin
      fail_cnt++;
      $error("wb_ack high on two consecutive cycles");
    end

  a_fifo_bound: assert property (@(posedge iclk) disable iff (ireset)
    rd.count <= bch_pkg::fifo_cnt_t'(`BCH_FIFO_DEPTH))  // occupancy 0..depth
    else begin
      fail_cnt++;
      $error("fifo count %0d above depth", rd.count);
    end

  //------------------------------------------------------------
  // per lane handshake
  //------------------------------------------------------------

  for (genvar i = 0; i < `BCH_LANES; i++) begin : g_lane
    // load only into an idle lane, which turns busy next cycle
    a_no_load_busy: assert property (@(posedge iclk) disable iff (ireset)
      lanes[i].load |=> (lanes[i].busy && !$past(lanes[i].busy)))
      else begin
        fail_cnt++;
        $error("lane %0d loaded while busy or did not take the load", i);
      end
    // done within busy, cw held until the collector acks
    a_done_busy: assert property (@(posedge iclk) disable iff (ireset)
      lanes[i].done |=> ($past(lanes[i].busy) &&
                         (lanes[i].done || $past(lanes[i].ack))))
      else begin
        fail_cnt++;
        $error("lane %0d done without busy or dropped done before ack", i);
      end
  end

endmodule

bind bch_enc_top bch_enc_properties i_bch_enc_properties (
  .iclk   (iclk),
  .ireset (ireset),
  .wb_ack (wb_ack),
  .lanes  (lane_if),
  .rd     (rd_if)
);

// ==== dv/bch_enc_tb.sv ====
/*
  directed tests for the multi-lane BCH(16,5) encoder
  single wishbone master, one request at a time, stb dropped after ack
  expected codewords come from polynomial division by the generator
*/

`timescale 1ns/1ps

`include "bch_config.svh"

module bch_enc_tb;

  localparam int CLK_PERIOD = 4;
  localparam int CAPACITY   = `BCH_LANES + `BCH_FIFO_DEPTH;  // held without reads
  localparam int MAX_CYCLES = 20000;  // about 10x the summed test length

  logic              iclk;
  logic              ireset;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  bch_pkg::wb_adr_t  wb_adr;
  bch_pkg::wb_dat_t  wb_wdat;
  bch_pkg::wb_dat_t  wb_rdat;
  logic              wb_ack;

  int errors;
  int checks;
  int cycles;  // watchdog only
  int seed;

  bch_enc_top i_bch_enc_top (
    .iclk    (iclk),
    .ireset  (ireset),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_wdat (wb_wdat),
    .wb_rdat (wb_rdat),
    .wb_ack  (wb_ack)
  );

  initial begin
    iclk = 1'b0;
    forever #(CLK_PERIOD / 2) iclk = ~iclk;
  end

  //------------------------------------------------------------
  // reference model and expected status
  //------------------------------------------------------------

  // remainder of m(x)*x^10 mod g(x), then overall even parity
  function automatic bch_pkg::cw_t ref_codeword(input bch_pkg::msg_t m);
    logic [`BCH_N-1:0] rem;
    logic [`BCH_N-1:0] gpoly;
    rem   = {m, {`BCH_NPAR{1'b0}}};
    gpoly = '0;
    gpoly[`BCH_NPAR:0] = `BCH_GPOLY;
    for (int i = `BCH_N - 1; i >= `BCH_NPAR; i--) begin
      if (rem[i]) rem = rem ^ (gpoly << (i - `BCH_NPAR));  // long division step
    end
    return {m, rem[`BCH_NPAR-1:0], ^{m, rem[`BCH_NPAR-1:0]}};
  endfunction

  function automatic bch_pkg::wb_dat_t status_word(input logic free, input logic ready,
                                                   input int count);
    bch_pkg::wb_dat_t s;
    s      = '0;
    s[0]   = free;
    s[1]   = ready;
    s[6:4] = count[2:0];
    return s;
  endfunction

  //------------------------------------------------------------
  // bus master
  //------------------------------------------------------------

  task automatic wb_write(input bch_pkg::wb_adr_t adr, input bch_pkg::wb_dat_t dat);
    @(posedge iclk);
    wb_cyc  <= 1'b1;
    wb_stb  <= 1'b1;
    wb_we   <= 1'b1;
    wb_adr  <= adr;
    wb_wdat <= dat;
    @(posedge iclk);
    while (!wb_ack) @(posedge iclk);  // wait states while no lane free
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input bch_pkg::wb_adr_t adr, output bch_pkg::wb_dat_t dat);
    @(posedge iclk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    @(posedge iclk);
    while (!wb_ack) @(posedge iclk);
    dat    = wb_rdat;  // registered with ack, stable here
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic write_msg(input bch_pkg::msg_t m);
    wb_write(2'd0, bch_pkg::wb_dat_t'(m));
  endtask

  task automatic pop_codeword(output bch_pkg::cw_t cw);
    bch_pkg::wb_dat_t d;
    wb_read(2'd1, d);
    cw = d[15:0];
  endtask

  //------------------------------------------------------------
  // checks
  //------------------------------------------------------------

  task automatic check_cw(input string name, input bch_pkg::cw_t exp, input bch_pkg::cw_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected %04h, actual %04h", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input bch_pkg::wb_dat_t exp,
                              input bch_pkg::wb_dat_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  // dmin 8 and even overall parity
  task automatic check_weight(input string name, input bch_pkg::cw_t cw);
    int w;
    w = $countones(cw);
    checks++;
    if ((w != 0 && w < 8) || (w % 2 != 0)) begin
      errors++;
      $display("%s: codeword %04h has weight %0d, not 0 or even and 8 or more", name, cw, w);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("test %s done, %0d errors", name, errors - err_before);
  endtask

  //------------------------------------------------------------
  // directed tests
  //------------------------------------------------------------

  task automatic test_reset_status();
    bch_pkg::wb_dat_t d;
    int e0;
    e0 = errors;
    wb_read(2'd2, d);
    check_status("reset_status", status_word(1'b1, 1'b0, 0), d);
    report_test("reset_status", e0);
  endtask

  task automatic test_single();
    bch_pkg::cw_t c;
    int e0;
    e0 = errors;
    write_msg(5'b10011);
    pop_codeword(c);
    check_cw("single", ref_codeword(5'b10011), c);
    check_weight("single", c);
    report_test("single", e0);
  endtask

  task automatic test_all_msgs();
    bch_pkg::cw_t c;
    int e0;
    e0 = errors;
    for (int m = 0; m < 32; m++) begin
      write_msg(bch_pkg::msg_t'(m));
      pop_codeword(c);
      check_cw("all_msgs", ref_codeword(bch_pkg::msg_t'(m)), c);
      check_weight("all_msgs", c);
    end
    report_test("all_msgs", e0);
  endtask

  // writes back to back, one read only when every slot holds a codeword
  task automatic test_burst();
    bch_pkg::cw_t exp_q[$];
    bch_pkg::msg_t m;
    bch_pkg::cw_t c;
    int e0;
    e0 = errors;
    for (int i = 0; i < 12; i++) begin
      if (exp_q.size() == CAPACITY) begin
        pop_codeword(c);
        check_cw("burst", exp_q.pop_front(), c);
      end
      m = bch_pkg::msg_t'($random(seed));
      write_msg(m);
      exp_q.push_back(ref_codeword(m));
    end
    while (exp_q.size() > 0) begin
      pop_codeword(c);
      check_cw("burst", exp_q.pop_front(), c);
    end
    report_test("burst", e0);
  endtask

  task automatic test_backpressure();
    bch_pkg::cw_t exp_q[$];
    bch_pkg::msg_t m;
    bch_pkg::cw_t c;
    bch_pkg::wb_dat_t d;
    int e0;
    e0 = errors;
    for (int i = 0; i < CAPACITY; i++) begin
      m = bch_pkg::msg_t'($random(seed));
      write_msg(m);
      exp_q.push_back(ref_codeword(m));
    end
    wb_read(2'd2, d);  // fifo full, lane at pointer holds done
    check_status("backpressure", status_word(1'b0, 1'b1, `BCH_FIFO_DEPTH), d);
    while (exp_q.size() > 0) begin
      pop_codeword(c);
      check_cw("backpressure", exp_q.pop_front(), c);
    end
    report_test("backpressure", e0);
  endtask

  task automatic test_read_wait();
    bch_pkg::cw_t c;
    time t0;
    int waited;
    int e0;
    e0 = errors;
    write_msg(5'b01101);
    t0 = $time;
    pop_codeword(c);  // fifo empty, read stalls on rdy
    waited = int'(($time - t0) / CLK_PERIOD);
    check_cw("read_wait", ref_codeword(5'b01101), c);
    checks++;
    if (waited < `BCH_N + 1) begin  // 16 serial steps at least
      errors++;
      $display("read_wait: read finished after %0d cycles, before the lane could finish", waited);
    end
    report_test("read_wait", e0);
  endtask

  //------------------------------------------------------------
  // run and verdict
  //------------------------------------------------------------

  initial begin
    seed    = 81521;
    errors  = 0;
    checks  = 0;
    ireset  = 1'b1;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_wdat = '0;
    repeat (10) @(posedge iclk);
    ireset <= 1'b0;
    test_reset_status();
    test_single();
    test_all_msgs();
    test_burst();
    test_backpressure();
    test_read_wait();
    errors = errors + i_bch_enc_top.i_bch_enc_properties.fail_cnt;  // assertion hits
    $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge iclk);
      cycles++;
    end
    $display("timeout: no verdict after %0d cycles, a bus request never got its ack", cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+common
common/bch_pkg.sv
common/bch_if.sv
rtl/bch_wb_slave.sv
rtl/bch_dispatch.sv
bch_enc/bch_enc_lane.sv
rtl/bch_collect.sv
rtl/bch_enc_top.sv
dv/bch_enc_properties.sv
dv/bch_enc_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = bch_enc_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
